// ==== hdl/boot_rom.sv ====
// Boot ROM, image built at elaboration from the seed rule
// Read word is registered at the accept edge, valid with ack
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module boot_rom (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  soc_bus_pkg::bus_access_t access_i,
  output logic [`SOC_DATA_W-1:0]   rdata_o
);

  localparam int unsigned RomAw = $clog2(`SOC_ROM_WORDS);

  logic [`SOC_DATA_W-1:0] rom_mem [`SOC_ROM_WORDS];
  logic [RomAw-1:0]       idx;

  for (genvar k = 0; k < `SOC_ROM_WORDS; k++) begin : g_image
    assign rom_mem[k] = `SOC_ROM_SEED ^ `SOC_DATA_W'(k);
  end

  assign idx = access_i.adr.word.index[RomAw-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (access_i.sel.rom) begin
      rdata_o <= rom_mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/bus_decode.sv ====
// Combinational region decode of the Wishbone request
// Selects one target only in the accept cycle, nothing otherwise
// ROM writes, GPIO and out-of-range offsets go to the error target
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module bus_decode (
  input  soc_bus_pkg::wb_req_t     wb_req_i,
  input  logic                     busy_i,
  output soc_bus_pkg::bus_access_t access_o
);

  import soc_bus_pkg::*;

  localparam logic [`SOC_ADDR_W-5:0] RomBytes   = (`SOC_ADDR_W-4)'(`SOC_ROM_WORDS * 4);
  localparam logic [`SOC_ADDR_W-5:0] RamBytes   = (`SOC_ADDR_W-4)'(`SOC_RAM_WORDS * 4);
  localparam logic [`SOC_ADDR_W-5:0] ClintBytes = (`SOC_ADDR_W-4)'(`SOC_CLINT_BYTES);

  logic         accept;
  addr_region_t rgn;
  bus_sel_t     sel;

  // Master holds the request until ack or err
  assign accept = wb_req_i.cyc & wb_req_i.stb & ~busy_i;
  assign rgn    = wb_req_i.adr.rgn;

  always_comb begin
    sel = '0;
    if (accept) begin
      case (rgn.region)
        `SOC_REGION_ROM: begin
          if (!wb_req_i.we && (rgn.offset < RomBytes)) begin
            sel.rom = 1'b1;
          end else begin
            sel.err = 1'b1;
          end
        end
        `SOC_REGION_CLINT: begin
          if (rgn.offset < ClintBytes) begin
            sel.clint = 1'b1;
          end else begin
            sel.err = 1'b1;
          end
        end
        `SOC_REGION_RAM: begin
          if (rgn.offset < RamBytes) begin
            sel.ram = 1'b1;
          end else begin
            sel.err = 1'b1;
          end
        end
        // Not implemented, answered by the error target
        `SOC_REGION_GPIO: sel.err = 1'b1;
        default:          sel.err = 1'b1;
      endcase
    end
  end

  // Payload passes unchanged, only the select is gated
  assign access_o.sel   = sel;
  assign access_o.we    = wb_req_i.we;
  assign access_o.adr   = wb_req_i.adr;
  assign access_o.be    = wb_req_i.sel;
  assign access_o.wdata = wb_req_i.wdata;

endmodule

`default_nettype wire

// ==== hdl/bus_response.sv ====
// Result stage, one registered ack or err per accepted access
// Read data comes from the target that was selected, zero on err
`timescale 1ns/1ps
`default_nettype none

module bus_response (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  soc_bus_pkg::bus_access_t access_i,
  input  soc_bus_pkg::tgt_rdata_t  rdata_i,
  output logic                     busy_o,
  output soc_bus_pkg::wb_rsp_t     wb_rsp_o
);

  import soc_bus_pkg::*;

  bus_sel_t sel_q;
  logic     ack_q;
  logic     err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      sel_q <= access_i.sel;
      ack_q <= access_i.sel.rom | access_i.sel.ram | access_i.sel.clint;
      err_q <= access_i.sel.err;
    end
  end

  // Blocks a new accept in the response cycle
  assign busy_o = ack_q | err_q;

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = err_q;

  // Target words are registered at the same edge as sel_q
  always_comb begin
    wb_rsp_o.rdata = '0;
    if (sel_q.rom) begin
      wb_rsp_o.rdata = rdata_i.rom;
    end else if (sel_q.ram) begin
      wb_rsp_o.rdata = rdata_i.ram;
    end else if (sel_q.clint) begin
      wb_rsp_o.rdata = rdata_i.clint;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/clint_timer.sv ====
// Core-local interrupt and timer block for one hart
// rtc_i is synchronized, mtime counts its rising edges
// 64-bit registers are accessed as two 32-bit words
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module clint_timer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rtc_i,
  input  soc_bus_pkg::bus_access_t access_i,
  output logic [`SOC_DATA_W-1:0]   rdata_o,
  output logic                     timer_irq_o,
  output logic                     ipi_o
);

  import soc_bus_pkg::*;

  // Word offsets inside the region
  localparam logic [13:0] WMsip   = 14'(`SOC_CLINT_MSIP >> 2);
  localparam logic [13:0] WCmpLo  = 14'(`SOC_CLINT_MTIMECMP >> 2);
  localparam logic [13:0] WCmpHi  = 14'((`SOC_CLINT_MTIMECMP + 4) >> 2);
  localparam logic [13:0] WTimeLo = 14'(`SOC_CLINT_MTIME >> 2);
  localparam logic [13:0] WTimeHi = 14'((`SOC_CLINT_MTIME + 4) >> 2);

  logic [2:0]  rtc_q;
  logic        tick;
  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtimecmp_d;
  logic        msip_q;
  logic        msip_d;
  logic [13:0] woff;
  logic        wr;
  logic [`SOC_DATA_W-1:0] rd_word;

  // --------------------
  // RTC sync and edge
  // --------------------
  // Two flops for sync, third for the edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
    end
  end

  assign tick = rtc_q[1] & ~rtc_q[2];

  assign woff = access_i.adr.rgn.offset[15:2];
  assign wr   = access_i.sel.clint & access_i.we;

  // Bus write wins over the count on the written half
  always_comb begin
    mtime_d    = tick ? mtime_q + 64'd1 : mtime_q;
    mtimecmp_d = mtimecmp_q;
    msip_d     = msip_q;
    if (wr) begin
      case (woff)
        WMsip:   msip_d = access_i.be[0] ? access_i.wdata[0] : msip_q;
        WCmpLo:  mtimecmp_d[31:0]  = merge_be(mtimecmp_q[31:0], access_i.wdata, access_i.be);
        WCmpHi:  mtimecmp_d[63:32] = merge_be(mtimecmp_q[63:32], access_i.wdata, access_i.be);
        WTimeLo: mtime_d[31:0]     = merge_be(mtime_q[31:0], access_i.wdata, access_i.be);
        WTimeHi: mtime_d[63:32]    = merge_be(mtime_q[63:32], access_i.wdata, access_i.be);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (woff)
      WMsip:   rd_word = {31'b0, msip_q};
      WCmpLo:  rd_word = mtimecmp_q[31:0];
      WCmpHi:  rd_word = mtimecmp_q[63:32];
      WTimeLo: rd_word = mtime_q[31:0];
      WTimeHi: rd_word = mtime_q[63:32];
      default: rd_word = '0;
    endcase
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      rdata_o    <= '0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      msip_q     <= msip_d;
      if (access_i.sel.clint) begin
        rdata_o <= rd_word;
      end
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// ==== hdl/soc_bus_pkg.sv ====
// Shared bus types of the Wishbone fabric
// The address is one word with a region view and a word view
`default_nettype none

`include "soc_bus_defines.svh"

package soc_bus_pkg;

  // Region nibble and offset, used by the decoder
  typedef struct packed {
    logic [3:0]               region;
    logic [`SOC_ADDR_W-5:0]   offset;
  } addr_region_t;

  // Word index and byte lane, used by the targets
  typedef struct packed {
    logic [`SOC_ADDR_W-3:0]   index;
    logic [1:0]               lane;
  } addr_word_t;

  typedef union packed {
    addr_region_t rgn;
    addr_word_t   word;
  } wb_addr_u;

  // Wishbone classic request from the master
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    wb_addr_u               adr;
    logic [`SOC_BE_W-1:0]   sel;
    logic [`SOC_DATA_W-1:0] wdata;
  } wb_req_t;

  typedef struct packed {
    logic                   ack;
    logic                   err;
    logic [`SOC_DATA_W-1:0] rdata;
  } wb_rsp_t;

  // One-hot target select, all zero outside the accept cycle
  typedef struct packed {
    logic rom;
    logic ram;
    logic clint;
    logic err;
  } bus_sel_t;

  typedef struct packed {
    bus_sel_t               sel;
    logic                   we;
    wb_addr_u               adr;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
  } bus_access_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rom;
    logic [`SOC_DATA_W-1:0] ram;
    logic [`SOC_DATA_W-1:0] clint;
  } tgt_rdata_t;

  // Byte-lane merge of write data into an old word
  function automatic logic [`SOC_DATA_W-1:0] merge_be(
    input logic [`SOC_DATA_W-1:0] old_word,
    input logic [`SOC_DATA_W-1:0] new_word,
    input logic [`SOC_BE_W-1:0]   be
  );
    logic [`SOC_DATA_W-1:0] res;
    res = old_word;
    for (int i = 0; i < `SOC_BE_W; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/soc_bus_top.sv ====
// Wishbone classic fabric with ROM, SRAM, CLINT and an error target
// One access every two cycles, response one cycle after accept
// rtc_i may be asynchronous to clk_i
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rtc_i,
  input  soc_bus_pkg::wb_req_t wb_req_i,
  output soc_bus_pkg::wb_rsp_t wb_rsp_o,
  output logic                 timer_irq_o,
  output logic                 ipi_o
);

  import soc_bus_pkg::*;

  bus_access_t access;
  tgt_rdata_t  tgt_rdata;
  logic        busy;

  // --------------------
  // Decode
  // --------------------
  bus_decode u_decode (
    .wb_req_i ( wb_req_i ),
    .busy_i   ( busy     ),
    .access_o ( access   )
  );

  // --------------------
  // Targets
  // --------------------
  boot_rom u_rom (
    .clk_i    ( clk_i         ),
    .rst_ni   ( rst_ni        ),
    .access_i ( access        ),
    .rdata_o  ( tgt_rdata.rom )
  );

  sram_bank u_ram (
    .clk_i    ( clk_i         ),
    .access_i ( access        ),
    .rdata_o  ( tgt_rdata.ram )
  );

  clint_timer u_clint (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .rtc_i       ( rtc_i           ),
    .access_i    ( access          ),
    .rdata_o     ( tgt_rdata.clint ),
    .timer_irq_o ( timer_irq_o     ),
    .ipi_o       ( ipi_o           )
  );

  // Response stage
  bus_response u_rsp (
    .clk_i    ( clk_i     ),
    .rst_ni   ( rst_ni    ),
    .access_i ( access    ),
    .rdata_i  ( tgt_rdata ),
    .busy_o   ( busy      ),
    .wb_rsp_o ( wb_rsp_o  )
  );

endmodule

`default_nettype wire

// ==== hdl/sram_bank.sv ====
// Word-addressed SRAM with byte-lane writes
// Contents are undefined after power-up
// A write returns the old word as read data
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module sram_bank (
  input  logic                     clk_i,
  input  soc_bus_pkg::bus_access_t access_i,
  output logic [`SOC_DATA_W-1:0]   rdata_o
);

  import soc_bus_pkg::*;

  localparam int unsigned RamAw = $clog2(`SOC_RAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`SOC_RAM_WORDS];
  logic [RamAw-1:0]       idx;

  assign idx = access_i.adr.word.index[RamAw-1:0];

  // --------------------
  // Write and read port
  // --------------------
  always_ff @(posedge clk_i) begin
    if (access_i.sel.ram) begin
      if (access_i.we) begin
        mem[idx] <= merge_be(mem[idx], access_i.wdata, access_i.be);
      end
      rdata_o <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== include/soc_bus_defines.svh ====
// Widths, address map and CLINT layout of the Wishbone fabric
// Regions are selected by the top address nibble only
// Offsets in a region at or beyond its size answer with err
`ifndef SOC_BUS_DEFINES_SVH
`define SOC_BUS_DEFINES_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_BE_W   (`SOC_DATA_W / 8)

// --------------------
// Address map
// --------------------
`define SOC_REGION_ROM   4'h0
`define SOC_REGION_CLINT 4'h2
`define SOC_REGION_GPIO  4'h4
`define SOC_REGION_RAM   4'h8

// Region sizes
`define SOC_ROM_WORDS   16
`define SOC_RAM_WORDS   256
`define SOC_CLINT_BYTES 32'h0001_0000

// ROM word k holds the seed XOR k
`define SOC_ROM_SEED 32'hB007_0000

// CLINT byte offsets, 64-bit registers take two words
`define SOC_CLINT_MSIP     32'h0000_0000
`define SOC_CLINT_MTIMECMP 32'h0000_4000
`define SOC_CLINT_MTIME    32'h0000_BFF8

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the fabric and its testbench with Verilator, then run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module soc_bus_tb \
  -f soc_bus_top.f \
  -o soc_bus_sim

# A failing run stops with a non-zero status, the output decides the result
sim_out=$(./obj_dir/soc_bus_sim 2>&1 || true)
echo "$sim_out"

if grep -qx "sim passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// ==== soc_bus_top.f ====
+incdir+include
hdl/soc_bus_pkg.sv
hdl/bus_decode.sv
hdl/boot_rom.sv
hdl/sram_bank.sv
hdl/clint_timer.sv
hdl/bus_response.sv
hdl/soc_bus_top.sv
tb/soc_bus_props.sv
tb/soc_bus_tb.sv

// ==== tb/soc_bus_props.sv ====
// Wishbone response protocol checks on the result stage
// Bound into bus_response, checks are off while in reset
`timescale 1ns/1ps
`default_nettype none

module soc_bus_props (
  input logic                     clk_i,
  input logic                     rst_ni,
  input soc_bus_pkg::bus_access_t access_i,
  input soc_bus_pkg::wb_rsp_t     wb_rsp_i
);

  // Count of fired checks, read by the testbench at the end
  int unsigned err_count = 0;
  logic        rsp_any;

  assign rsp_any = wb_rsp_i.ack | wb_rsp_i.err;

  // --------------------
  // Response rules
  // --------------------
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_rsp_i.ack && wb_rsp_i.err))
    else begin
      err_count++;
      $error("ack and err are high in the same cycle");
    end

  // Every response needs a target select one cycle earlier
  a_rsp_after_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_any |-> $past(|access_i.sel))
    else begin
      err_count++;
      $error("response without a select in the cycle before");
    end

  a_no_back_to_back: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_any |=> !rsp_any)
    else begin
      err_count++;
      $error("response in two consecutive cycles");
    end

endmodule

bind bus_response soc_bus_props u_props (
  .clk_i    ( clk_i    ),
  .rst_ni   ( rst_ni   ),
  .access_i ( access_i ),
  .wb_rsp_i ( wb_rsp_o )
);

`default_nettype wire

// ==== tb/soc_bus_tb.sv ====
// Directed testbench for the Wishbone fabric
// Inputs change on the falling clock edge and outputs are sampled there
// RAM data is random from a fixed seed
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module soc_bus_tb;

  import soc_bus_pkg::*;

  localparam int WaitLimit  = 64;
  localparam int TimerTicks = 5;
  localparam int RamSamples = 8;

  localparam logic [31:0] MsipAddr   = {`SOC_REGION_CLINT, 28'(`SOC_CLINT_MSIP)};
  localparam logic [31:0] CmpLoAddr  = {`SOC_REGION_CLINT, 28'(`SOC_CLINT_MTIMECMP)};
  localparam logic [31:0] CmpHiAddr  = {`SOC_REGION_CLINT, 28'(`SOC_CLINT_MTIMECMP + 4)};
  localparam logic [31:0] TimeLoAddr = {`SOC_REGION_CLINT, 28'(`SOC_CLINT_MTIME)};
  localparam logic [31:0] TimeHiAddr = {`SOC_REGION_CLINT, 28'(`SOC_CLINT_MTIME + 4)};

  logic        clk;
  logic        rst_n;
  logic        rtc;
  wb_req_t     req;
  wb_rsp_t     rsp;
  logic        timer_irq;
  logic        ipi;
  int          seed;
  logic [31:0] rd_word;
  logic        rd_ack;
  logic        rd_err;
  logic [31:0] ram_exp [RamSamples];
  logic [31:0] lane_data;

  soc_bus_top u_dut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .rtc_i       ( rtc       ),
    .wb_req_i    ( req       ),
    .wb_rsp_o    ( rsp       ),
    .timer_irq_o ( timer_irq ),
    .ipi_o       ( ipi       )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Protocol assertions are watched every cycle
  always @(negedge clk) begin
    if (u_dut.u_rsp.u_props.err_count != 0) begin
      report_failure("a bus protocol assertion fired");
    end
  end

  // --------------------
  // Checking helpers
  // --------------------
  task automatic halt_run();
    $display("sim failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic report_failure(input string why);
    $display("Failure: %s", why);
    halt_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      halt_run();
    end
  endtask

  // Expected word after a byte-lane write
  function automatic logic [31:0] apply_lanes(input logic [31:0] old_word,
                                              input logic [31:0] wr_word,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (wr_word & mask);
  endfunction

  function automatic logic [31:0] rom_addr(input int k);
    return {`SOC_REGION_ROM, 28'(k) << 2};
  endfunction

  function automatic logic [31:0] ram_addr(input int k);
    return {`SOC_REGION_RAM, 28'(k) << 2};
  endfunction

  // --------------------
  // Bus access
  // --------------------
  task automatic bus_xfer(input logic we, input logic [31:0] addr,
                          input logic [3:0] be, input logic [31:0] wdata);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    @(negedge clk);
    req.cyc   = 1'b1;
    req.stb   = 1'b1;
    req.we    = we;
    req.adr   = addr;
    req.sel   = be;
    req.wdata = wdata;
    while (!done) begin
      @(negedge clk);
      if (rsp.ack || rsp.err) begin
        done = 1'b1;
      end else begin
        waited++;
        if (waited >= WaitLimit) report_failure("no ack or err came back on the bus");
      end
    end
    rd_word = rsp.rdata;
    rd_ack  = rsp.ack;
    rd_err  = rsp.err;
    req     = '0;
  endtask

  // Request held high across responses, each ack needs an idle cycle after it
  task automatic held_reads(input string name, input logic [31:0] addr,
                            input logic [31:0] exp, input int count);
    int seen;
    int waited;
    seen   = 0;
    waited = 0;
    @(negedge clk);
    req.cyc   = 1'b1;
    req.stb   = 1'b1;
    req.we    = 1'b0;
    req.adr   = addr;
    req.sel   = 4'hF;
    req.wdata = 32'h0;
    while (seen < count) begin
      @(negedge clk);
      if (rsp.err) begin
        report_failure("err came back on a held read request");
      end else if (rsp.ack) begin
        check_value(name, exp, rsp.rdata);
        seen++;
      end else begin
        waited++;
        if (waited >= WaitLimit) report_failure("no ack came back on a held read request");
      end
    end
    req = '0;
  endtask

  task automatic read_ok(input string name, input logic [31:0] addr, input logic [31:0] exp);
    bus_xfer(1'b0, addr, 4'hF, 32'h0);
    check_value({name, "_ack"}, 32'd1, 32'(rd_ack));
    check_value(name, exp, rd_word);
  endtask

  task automatic write_ok(input string name, input logic [31:0] addr,
                          input logic [3:0] be, input logic [31:0] wdata);
    bus_xfer(1'b1, addr, be, wdata);
    check_value({name, "_ack"}, 32'd1, 32'(rd_ack));
    check_value({name, "_err"}, 32'd0, 32'(rd_err));
  endtask

  task automatic expect_err(input string name, input logic we, input logic [31:0] addr);
    bus_xfer(we, addr, 4'hF, 32'hDEAD_BEEF);
    check_value({name, "_err"}, 32'd1, 32'(rd_err));
    check_value({name, "_ack"}, 32'd0, 32'(rd_ack));
    check_value({name, "_rdata"}, 32'd0, rd_word);
  endtask

  // One rtc period of eight clocks, wide enough for the synchronizer
  task automatic rtc_pulse();
    @(negedge clk);
    rtc = 1'b1;
    repeat (4) @(negedge clk);
    rtc = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  task automatic wait_for_irq();
    int waited;
    waited = 0;
    while (!timer_irq) begin
      @(negedge clk);
      waited++;
      if (waited >= WaitLimit) report_failure("timer interrupt did not rise");
    end
  endtask

  initial begin
    seed  = 32'h97cfec6a;
    req   = '0;
    rtc   = 1'b0;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state
    check_value("reset_ack", 32'd0, 32'(rsp.ack));
    check_value("reset_err", 32'd0, 32'(rsp.err));
    check_value("reset_timer_irq", 32'd0, 32'(timer_irq));
    check_value("reset_ipi", 32'd0, 32'(ipi));
    read_ok("reset_mtime_lo", TimeLoAddr, 32'd0);
    read_ok("reset_mtime_hi", TimeHiAddr, 32'd0);

    for (int k = 0; k < `SOC_ROM_WORDS; k++) begin
      read_ok("rom_read", rom_addr(k), `SOC_ROM_SEED ^ 32'(k));
    end

    // Back-to-back requests with stb kept high
    held_reads("rom_held_read", rom_addr(5), `SOC_ROM_SEED ^ 32'd5, 4);

    // RAM full words, then partial lanes
    for (int k = 0; k < RamSamples; k++) begin
      ram_exp[k] = $random(seed);
      write_ok("ram_write", ram_addr(k * 33), 4'hF, ram_exp[k]);
    end
    for (int k = 0; k < RamSamples; k++) begin
      read_ok("ram_read", ram_addr(k * 33), ram_exp[k]);
    end
    lane_data = $random(seed);
    write_ok("ram_lane_write", ram_addr(3 * 33), 4'b0101, lane_data);
    ram_exp[3] = apply_lanes(ram_exp[3], lane_data, 4'b0101);
    read_ok("ram_lane_read", ram_addr(3 * 33), ram_exp[3]);
    lane_data = $random(seed);
    write_ok("ram_lane_write", ram_addr(6 * 33), 4'b1000, lane_data);
    ram_exp[6] = apply_lanes(ram_exp[6], lane_data, 4'b1000);
    read_ok("ram_lane_read", ram_addr(6 * 33), ram_exp[6]);

    expect_err("rom_write", 1'b1, rom_addr(1));
    expect_err("gpio_read", 1'b0, {`SOC_REGION_GPIO, 28'h000_0010});
    expect_err("ram_beyond", 1'b0, ram_addr(`SOC_RAM_WORDS));

    // Software interrupt
    write_ok("msip_set", MsipAddr, 4'hF, 32'd1);
    check_value("ipi_high", 32'd1, 32'(ipi));
    read_ok("msip_read", MsipAddr, 32'd1);
    write_ok("msip_clear", MsipAddr, 4'hF, 32'd0);
    check_value("ipi_low", 32'd0, 32'(ipi));

    // Timer compare
    write_ok("mtime_lo_write", TimeLoAddr, 4'hF, 32'd0);
    write_ok("mtime_hi_write", TimeHiAddr, 4'hF, 32'd0);
    write_ok("mtimecmp_lo_write", CmpLoAddr, 4'hF, 32'(TimerTicks));
    write_ok("mtimecmp_hi_write", CmpHiAddr, 4'hF, 32'd0);
    check_value("timer_irq_idle", 32'd0, 32'(timer_irq));
    for (int k = 1; k < TimerTicks; k++) begin
      rtc_pulse();
      check_value("timer_irq_early", 32'd0, 32'(timer_irq));
    end
    @(negedge clk);
    rtc = 1'b1;
    wait_for_irq();
    rtc = 1'b0;
    repeat (4) @(negedge clk);
    read_ok("mtime_after_ticks", TimeLoAddr, 32'(TimerTicks));
    check_value("timer_irq_held", 32'd1, 32'(timer_irq));

    if (u_dut.u_rsp.u_props.err_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      report_failure("a bus protocol assertion fired");
    end
  end

endmodule

`default_nettype wire
